// ==== include/isa_fields.svh ====
`ifndef ISA_FIELDS_SVH
`define ISA_FIELDS_SVH

`default_nettype none

// instruction field ranges
`define opcode_bits 6:0
`define rd_bits     11:7
`define funct3_bits 14:12
`define rs1_bits    19:15
`define rs2_bits    24:20
`define funct7_bits 31:25

// immediate assembly, all sign-extended from bit 31
`define I_IMM(i) {{20{i[31]}}, i[31:20]}
`define S_IMM(i) {{20{i[31]}}, i[31:25], i[11:7]}
`define B_IMM(i) {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0}
`define U_IMM(i) {i[31:12], 12'b0}
`define J_IMM(i) {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0}

`default_nettype wire

`endif

// ==== rtl/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [4:0]  arf_id_t;
    typedef logic [31:0] imm_t;

    // memory access size, same encoding as funct3[1:0]
    typedef enum logic [1:0] {
        BYTE     = 2'b00,
        HALFWORD = 2'b01,
        WORD     = 2'b10,
        ERROR    = 2'b11
    } req_width_t;

    // major opcodes
    localparam opcode_t OP_OPCODE     = 7'b0110011; // register-register alu
    localparam opcode_t OP_IMM_OPCODE = 7'b0010011; // register-immediate alu
    localparam opcode_t LD_OPCODE     = 7'b0000011;
    localparam opcode_t ST_OPCODE     = 7'b0100011;
    localparam opcode_t BR_OPCODE     = 7'b1100011;
    localparam opcode_t JALR_OPCODE   = 7'b1100111;
    localparam opcode_t JAL_OPCODE    = 7'b1101111;
    localparam opcode_t LUI_OPCODE    = 7'b0110111;
    localparam opcode_t AUIPC_OPCODE  = 7'b0010111;

    // minor functions that need funct7[5] to tell apart
    localparam funct3_t SUB_FUNCT3  = 3'b000; // add / sub
    localparam funct3_t SRA_FUNCT3  = 3'b101; // srl / sra
    localparam funct3_t SRAI_FUNCT3 = 3'b101; // srli / srai

endpackage : rv_isa_pkg

`default_nettype wire

// ==== rtl/uop_pkg.sv ====
`default_nettype none

package uop_pkg;

    import rv_isa_pkg::*;

    localparam int SEQ_BITS          = 6;
    localparam int INSTR_QUEUE_DEPTH = 4;
    localparam int ISSUE_QUEUE_DEPTH = 4;

    typedef logic [SEQ_BITS-1:0] seq_tag_t; // program-order tag, wraps

    typedef struct packed {
        seq_tag_t   seq;
        logic       rs1_valid;   // valid means the operand exists
        logic       rs2_valid;
        logic       rd_valid;
        arf_id_t    rs1;
        arf_id_t    rs2;
        arf_id_t    rd;
        funct3_t    funct3;
        imm_t       imm;
        logic       is_r_type;
        logic       is_i_type;
        logic       is_s_type;
        logic       is_b_type;
        logic       is_u_type;   // lui and auipc
        logic       is_j_type;   // jal only
        logic       is_sub;
        logic       is_sra_srai;
        logic       is_lui;
        logic       is_jalr;
        logic       is_ls_instr;
        req_width_t ls_width;
        logic       ld_sign;
    } decoded_uop_t;

endpackage : uop_pkg

`default_nettype wire

// ==== rtl/decode.sv ====
`timescale 1ns/1ps
`include "isa_fields.svh"
`default_nettype none

module decode
    import rv_isa_pkg::*;
    import uop_pkg::*;
(
    input  instr_t       instr,
    output decoded_uop_t uop    // seq stays zero here, dispatch fills it
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    is_r;
    logic    is_i;
    logic    is_s;
    logic    is_b;
    logic    is_u;
    logic    is_j;

    assign opcode = instr[`opcode_bits];
    assign funct3 = instr[`funct3_bits];
    assign funct7 = instr[`funct7_bits];

    assign is_r = (opcode == OP_OPCODE);
    assign is_i = (opcode == OP_IMM_OPCODE) || (opcode == LD_OPCODE) ||
                  (opcode == JALR_OPCODE);
    assign is_s = (opcode == ST_OPCODE);
    assign is_b = (opcode == BR_OPCODE);
    assign is_u = (opcode == LUI_OPCODE) || (opcode == AUIPC_OPCODE);
    assign is_j = (opcode == JAL_OPCODE);

    always_comb begin
        uop = '0;

        uop.is_r_type = is_r;
        uop.is_i_type = is_i;
        uop.is_s_type = is_s;
        uop.is_b_type = is_b;
        uop.is_u_type = is_u;
        uop.is_j_type = is_j;

        uop.rs1_valid = is_r || is_i || is_s || is_b;
        uop.rs2_valid = is_r || is_s || is_b;
        uop.rd_valid  = is_r || is_i || is_u || is_j;
        uop.rs1       = instr[`rs1_bits];
        uop.rs2       = instr[`rs2_bits];
        uop.rd        = instr[`rd_bits];
        uop.funct3    = funct3;

        if (is_i)      uop.imm = `I_IMM(instr);
        else if (is_s) uop.imm = `S_IMM(instr);
        else if (is_b) uop.imm = `B_IMM(instr);
        else if (is_u) uop.imm = `U_IMM(instr);
        else if (is_j) uop.imm = `J_IMM(instr);
        else           uop.imm = '0;    // r-type and unknown opcodes

        uop.is_sub      = is_r && (funct3 == SUB_FUNCT3) && funct7[5];
        uop.is_sra_srai = (is_r && (funct3 == SRA_FUNCT3) && funct7[5]) ||
                          ((opcode == OP_IMM_OPCODE) && (funct3 == SRAI_FUNCT3) && funct7[5]);
        uop.is_lui      = (opcode == LUI_OPCODE);
        uop.is_jalr     = (opcode == JALR_OPCODE);
        uop.is_ls_instr = (opcode == LD_OPCODE) || (opcode == ST_OPCODE);

        case (funct3[1:0])
            2'b00:   uop.ls_width = BYTE;
            2'b01:   uop.ls_width = HALFWORD;
            2'b10:   uop.ls_width = WORD;
            default: uop.ls_width = ERROR;
        endcase
        uop.ld_sign = funct3[2];    // set means lbu/lhu, i.e. zero extend
    end

endmodule : decode

`default_nettype wire

// ==== rtl/sync_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_queue #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t            mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                full;
    logic                push;
    logic                pop;

    assign full      = (count == (PTR_BITS+1)'(DEPTH));
    assign out_valid = (count != '0);
    assign in_ready  = !full || out_ready;  // a pop frees the slot for this push
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_data  = mem[rd_ptr];         // registered storage, no bypass

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : sync_queue

`default_nettype wire

// ==== rtl/dispatch_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch_router
    import uop_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  decoded_uop_t uop,
    input  logic         uop_valid,
    output logic         uop_ready,
    output decoded_uop_t int_uop,
    output decoded_uop_t ls_uop,
    output logic         int_valid,
    output logic         ls_valid,
    input  logic         int_ready,
    input  logic         ls_ready
);

    seq_tag_t     seq_q;        // tag for the next micro-op in program order
    decoded_uop_t tagged_uop;
    logic         to_ls;
    logic         accept;

    always_comb begin
        tagged_uop     = uop;
        tagged_uop.seq = seq_q;
    end

    assign to_ls = uop.is_ls_instr;

    // both queues see the same payload, only one valid is raised
    assign int_uop   = tagged_uop;
    assign ls_uop    = tagged_uop;
    assign int_valid = uop_valid && !to_ls;
    assign ls_valid  = uop_valid && to_ls;

    assign uop_ready = to_ls ? ls_ready : int_ready;   // head waits on its own queue
    assign accept    = uop_valid && uop_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seq_q <= '0;
        end else if (accept) begin
            seq_q <= seq_q + seq_tag_t'(1);    // wraps at 2^SEQ_BITS
        end
    end

endmodule : dispatch_router

`default_nettype wire

// ==== rtl/decode_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_frontend
    import rv_isa_pkg::*;
    import uop_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  instr_t       instr,
    input  logic         instr_valid,
    output logic         instr_ready,
    output decoded_uop_t int_uop,
    output logic         int_valid,
    input  logic         int_ready,
    output decoded_uop_t ls_uop,
    output logic         ls_valid,
    input  logic         ls_ready
);

    instr_t       head_instr;      // oldest buffered instruction
    logic         head_valid;
    logic         head_pop;
    decoded_uop_t dec_uop;
    decoded_uop_t int_push_uop;
    decoded_uop_t ls_push_uop;
    logic         int_push_valid;
    logic         int_push_ready;
    logic         ls_push_valid;
    logic         ls_push_ready;

    sync_queue #(
        .payload_t (instr_t),
        .DEPTH     (INSTR_QUEUE_DEPTH)
    ) instr_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (instr),
        .in_valid  (instr_valid),
        .in_ready  (instr_ready),
        .out_data  (head_instr),
        .out_valid (head_valid),
        .out_ready (head_pop)
    );

    decode decoder (
        .instr (head_instr),
        .uop   (dec_uop)
    );

    dispatch_router router (
        .clk       (clk),
        .rst_n     (rst_n),
        .uop       (dec_uop),
        .uop_valid (head_valid),
        .uop_ready (head_pop),
        .int_uop   (int_push_uop),
        .ls_uop    (ls_push_uop),
        .int_valid (int_push_valid),
        .ls_valid  (ls_push_valid),
        .int_ready (int_push_ready),
        .ls_ready  (ls_push_ready)
    );

    sync_queue #(
        .payload_t (decoded_uop_t),
        .DEPTH     (ISSUE_QUEUE_DEPTH)
    ) int_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (int_push_uop),
        .in_valid  (int_push_valid),
        .in_ready  (int_push_ready),
        .out_data  (int_uop),
        .out_valid (int_valid),
        .out_ready (int_ready)
    );

    sync_queue #(
        .payload_t (decoded_uop_t),
        .DEPTH     (ISSUE_QUEUE_DEPTH)
    ) ls_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (ls_push_uop),
        .in_valid  (ls_push_valid),
        .in_ready  (ls_push_ready),
        .out_data  (ls_uop),
        .out_valid (ls_valid),
        .out_ready (ls_ready)
    );

endmodule : decode_frontend

`default_nettype wire

// ==== verif/decode_frontend_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_frontend_properties
    import rv_isa_pkg::*;
    import uop_pkg::*;
(
    input logic         clk,
    input logic         rst_n,
    input instr_t       instr,
    input logic         instr_valid,
    input logic         instr_ready,
    input decoded_uop_t int_uop,
    input logic         int_valid,
    input logic         int_ready,
    input decoded_uop_t ls_uop,
    input logic         ls_valid,
    input logic         ls_ready
);

    int unsigned assert_fails = 0;  // summed into the testbench result

    instr_held: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid && !instr_ready |=> instr_valid && $stable(instr))
    else begin
        assert_fails++;
        $error("instr dropped or changed before instr_ready");
    end

    int_held: assert property (@(posedge clk) disable iff (!rst_n)
        int_valid && !int_ready |=> int_valid && $stable(int_uop))
    else begin
        assert_fails++;
        $error("int_uop dropped or changed before int_ready");
    end

    ls_held: assert property (@(posedge clk) disable iff (!rst_n)
        ls_valid && !ls_ready |=> ls_valid && $stable(ls_uop))
    else begin
        assert_fails++;
        $error("ls_uop dropped or changed before ls_ready");
    end

    int_not_ls: assert property (@(posedge clk) disable iff (!rst_n)
        int_valid |-> !int_uop.is_ls_instr)
    else begin
        assert_fails++;
        $error("load/store micro-op on int_out");
    end

    ls_only_ls: assert property (@(posedge clk) disable iff (!rst_n)
        ls_valid |-> ls_uop.is_ls_instr)
    else begin
        assert_fails++;
        $error("non load/store micro-op on ls_out");
    end

    // queues clear on the first edge with rst_n low
    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |=> !int_valid && !ls_valid)
    else begin
        assert_fails++;
        $error("output valid high during reset");
    end

endmodule : decode_frontend_properties

bind decode_frontend decode_frontend_properties props (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr       (instr),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .int_uop     (int_uop),
    .int_valid   (int_valid),
    .int_ready   (int_ready),
    .ls_uop      (ls_uop),
    .ls_valid    (ls_valid),
    .ls_ready    (ls_ready)
);

`default_nettype wire

// ==== verif/decode_frontend_tb.sv ====
`timescale 1ns/1ps
`include "isa_fields.svh"
`default_nettype none

module decode_frontend_tb
    import rv_isa_pkg::*;
    import uop_pkg::*;
();

    localparam int FMT_COUNT   = 300;
    localparam int BP_COUNT    = 200;
    localparam int CYCLE_LIMIT = (FMT_COUNT + BP_COUNT) * 20 + 200;
    localparam int DRAIN_LIMIT = 100;   // cycles allowed for the issue queues to empty

    logic         clk;
    logic         rst_n;
    instr_t       instr;
    logic         instr_valid;
    logic         instr_ready;
    decoded_uop_t int_uop;
    logic         int_valid;
    logic         int_ready;
    decoded_uop_t ls_uop;
    logic         ls_valid;
    logic         ls_ready;

    logic [31:0]  lfsr_state;
    logic         bp_mode;      // random readies on both outputs
    seq_tag_t     next_tag;     // model tag of the next accepted instruction
    decoded_uop_t int_sb[$];
    decoded_uop_t ls_sb[$];
    int           test_errs[1:6];
    int           accepted;
    int           int_seen;
    int           ls_seen;
    int           cycles;

    decode_frontend UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic instr_t random_instr();
        logic [4:0] pick;
        opcode_t    op;
        pick = 5'(random_bits(5));
        if (pick >= 5'd27) begin
            op = {5'(random_bits(5)), 2'b10};   // low bits never 11, so not rv32i
        end else begin
            case (pick % 5'd9)
                0:       op = OP_OPCODE;
                1:       op = OP_IMM_OPCODE;
                2:       op = LD_OPCODE;
                3:       op = ST_OPCODE;
                4:       op = BR_OPCODE;
                5:       op = JALR_OPCODE;
                6:       op = JAL_OPCODE;
                7:       op = LUI_OPCODE;
                default: op = AUIPC_OPCODE;
            endcase
        end
        return {25'(random_bits(25)), op};
    endfunction

    // reference decode
    function automatic decoded_uop_t predict_uop(instr_t raw, seq_tag_t tag);
        decoded_uop_t u;
        opcode_t      op;
        funct3_t      f3;
        u  = '0;
        op = raw[`opcode_bits];
        f3 = raw[`funct3_bits];
        case (op)
            OP_OPCODE:                             u.is_r_type = 1'b1;
            OP_IMM_OPCODE, LD_OPCODE, JALR_OPCODE: u.is_i_type = 1'b1;
            ST_OPCODE:                             u.is_s_type = 1'b1;
            BR_OPCODE:                             u.is_b_type = 1'b1;
            LUI_OPCODE, AUIPC_OPCODE:              u.is_u_type = 1'b1;
            JAL_OPCODE:                            u.is_j_type = 1'b1;
            default: ;                             // unknown, no format
        endcase
        u.seq       = tag;
        u.rs1       = raw[`rs1_bits];
        u.rs2       = raw[`rs2_bits];
        u.rd        = raw[`rd_bits];
        u.funct3    = f3;
        u.rs1_valid = u.is_r_type || u.is_i_type || u.is_s_type || u.is_b_type;
        u.rs2_valid = u.is_r_type || u.is_s_type || u.is_b_type;
        u.rd_valid  = u.is_r_type || u.is_i_type || u.is_u_type || u.is_j_type;
        if (u.is_i_type) u.imm = `I_IMM(raw);
        if (u.is_s_type) u.imm = `S_IMM(raw);
        if (u.is_b_type) u.imm = `B_IMM(raw);
        if (u.is_u_type) u.imm = `U_IMM(raw);
        if (u.is_j_type) u.imm = `J_IMM(raw);
        u.is_sub      = (op == OP_OPCODE) && (f3 == SUB_FUNCT3) && raw[30];
        u.is_sra_srai = ((op == OP_OPCODE) && (f3 == SRA_FUNCT3) && raw[30]) ||
                        ((op == OP_IMM_OPCODE) && (f3 == SRAI_FUNCT3) && raw[30]);
        u.is_lui      = (op == LUI_OPCODE);
        u.is_jalr     = (op == JALR_OPCODE);
        u.is_ls_instr = (op == LD_OPCODE) || (op == ST_OPCODE);
        case (f3[1:0])
            2'b00:   u.ls_width = BYTE;
            2'b01:   u.ls_width = HALFWORD;
            2'b10:   u.ls_width = WORD;
            default: u.ls_width = ERROR;
        endcase
        u.ld_sign = f3[2];
        return u;
    endfunction

    function automatic int pick_test(int id);
        return bp_mode ? 5 : id;    // under back-pressure every mismatch counts for test 5
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act, int id);
        if (act !== exp) begin
            $display("ERR %0t ns %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
            test_errs[id]++;
        end
    endtask

    task automatic compare_uop(string port, decoded_uop_t exp, decoded_uop_t act);
        int fmt;
        int ls;
        fmt = pick_test(2);
        ls  = pick_test(4);
        check_value({port, ".seq"}, exp.seq, act.seq, 5);
        check_value({port, ".is_r_type"}, exp.is_r_type, act.is_r_type, fmt);
        check_value({port, ".is_i_type"}, exp.is_i_type, act.is_i_type, fmt);
        check_value({port, ".is_s_type"}, exp.is_s_type, act.is_s_type, fmt);
        check_value({port, ".is_b_type"}, exp.is_b_type, act.is_b_type, fmt);
        check_value({port, ".is_u_type"}, exp.is_u_type, act.is_u_type, fmt);
        check_value({port, ".is_j_type"}, exp.is_j_type, act.is_j_type, fmt);
        check_value({port, ".rs1_valid"}, exp.rs1_valid, act.rs1_valid, fmt);
        check_value({port, ".rs2_valid"}, exp.rs2_valid, act.rs2_valid, fmt);
        check_value({port, ".rd_valid"}, exp.rd_valid, act.rd_valid, fmt);
        check_value({port, ".rs1"}, exp.rs1, act.rs1, fmt);
        check_value({port, ".rs2"}, exp.rs2, act.rs2, fmt);
        check_value({port, ".rd"}, exp.rd, act.rd, fmt);
        check_value({port, ".funct3"}, exp.funct3, act.funct3, fmt);
        check_value({port, ".is_sub"}, exp.is_sub, act.is_sub, fmt);
        check_value({port, ".is_sra_srai"}, exp.is_sra_srai, act.is_sra_srai, fmt);
        check_value({port, ".is_lui"}, exp.is_lui, act.is_lui, fmt);
        check_value({port, ".is_jalr"}, exp.is_jalr, act.is_jalr, fmt);
        check_value({port, ".imm"}, exp.imm, act.imm, pick_test(3));
        check_value({port, ".is_ls_instr"}, exp.is_ls_instr, act.is_ls_instr, ls);
        check_value({port, ".ls_width"}, exp.ls_width, act.ls_width, ls);
        check_value({port, ".ld_sign"}, exp.ld_sign, act.ld_sign, ls);
    endtask

    // handshakes are sampled mid-cycle, they complete on the next rising edge
    always @(negedge clk) begin
        decoded_uop_t exp;
        if (rst_n) begin
            if (instr_valid && instr_ready) begin
                exp      = predict_uop(instr, next_tag);
                next_tag = seq_tag_t'(next_tag + 1);
                if (exp.is_ls_instr) ls_sb.push_back(exp);
                else int_sb.push_back(exp);
                accepted++;
            end
            if (int_valid && int_ready) begin
                int_seen++;
                if (int_sb.size() == 0) begin
                    $display("micro-op on int_out at %0t ns with no prediction pending", $time);
                    test_errs[pick_test(4)]++;
                end else begin
                    exp = int_sb.pop_front();
                    compare_uop("int_uop", exp, int_uop);
                end
            end
            if (ls_valid && ls_ready) begin
                ls_seen++;
                if (ls_sb.size() == 0) begin
                    $display("micro-op on ls_out at %0t ns with no prediction pending", $time);
                    test_errs[pick_test(4)]++;
                end else begin
                    exp = ls_sb.pop_front();
                    compare_uop("ls_uop", exp, ls_uop);
                end
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
        if (bp_mode) begin
            int_ready = lfsr_bit();
            ls_ready  = lfsr_bit();
        end else begin
            int_ready = 1'b1;
            ls_ready  = 1'b1;
        end
    endtask

    task automatic send_instr(instr_t value);
        instr       = value;
        instr_valid = 1'b1;
        @(negedge clk);
        while (!instr_ready) begin
            next_cycle();
            @(negedge clk);
        end
        next_cycle();   // transfer on this edge
    endtask

    task automatic drain_outputs();
        int waited;
        waited      = 0;
        instr_valid = 1'b0;
        while ((int_sb.size() != 0 || ls_sb.size() != 0) && waited < DRAIN_LIMIT) begin
            next_cycle();
            waited++;
        end
        repeat (4) next_cycle();    // room for a stray micro-op to show up
    endtask

    task automatic check_reset_state();
        check_value("instr_ready", 1, instr_ready, 1);
        check_value("int_valid", 0, int_valid, 1);
        check_value("ls_valid", 0, ls_valid, 1);
    endtask

    task automatic report_test(int id, string name);
        if (test_errs[id] == 0) $display("test %0d %s: ok", id, name);
        else $display("test %0d %s: %0d errors", id, name, test_errs[id]);
    endtask

    initial begin
        int total;
        int failed;
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        int_ready   = 1'b1;
        ls_ready    = 1'b1;
        lfsr_state  = 32'h4b05_2ac4;
        bp_mode     = 1'b0;
        next_tag    = '0;
        accepted    = 0;
        int_seen    = 0;
        ls_seen     = 0;
        cycles      = 0;
        foreach (test_errs[t]) test_errs[t] = 0;

        for (int i = 0; i < 10; i++) begin
            next_cycle();
            if (i == 9) rst_n = 1'b1;
            @(negedge clk);
            check_reset_state();
        end
        next_cycle();
        @(negedge clk);
        check_reset_state();
        report_test(1, "reset state");

        next_cycle();
        for (int n = 0; n < FMT_COUNT; n++) send_instr(random_instr());
        drain_outputs();
        report_test(2, "format decode");
        report_test(3, "immediates");
        report_test(4, "load/store attributes and routing");

        bp_mode = 1'b1;
        for (int n = 0; n < BP_COUNT; n++) send_instr(random_instr());
        drain_outputs();
        bp_mode = 1'b0;
        report_test(5, "back-pressure and order");

        if (int_sb.size() != 0 || ls_sb.size() != 0) begin
            $display("%0d int and %0d load/store micro-ops never came out",
                     int_sb.size(), ls_sb.size());
            test_errs[6]++;
        end
        check_value("output_count", accepted, int_seen + ls_seen, 6);
        report_test(6, "completion");

        total  = UUT.props.assert_fails;
        failed = 0;
        foreach (test_errs[t]) begin
            total += test_errs[t];
            if (test_errs[t] != 0) failed++;
        end
        $display("tests run: 6, tests failed: %0d, errors: %0d, assertion failures: %0d",
                 failed, total, UUT.props.assert_fails);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : decode_frontend_tb

`default_nettype wire

// ==== decode_frontend.f ====
+incdir+include
rtl/rv_isa_pkg.sv
rtl/uop_pkg.sv
rtl/decode.sv
rtl/sync_queue.sv
rtl/dispatch_router.sv
rtl/decode_frontend.sv
verif/decode_frontend_properties.sv
verif/decode_frontend_tb.sv

// ==== Bender.yml ====
package:
  name: decode_frontend

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/rv_isa_pkg.sv
      - rtl/uop_pkg.sv
      - rtl/decode.sv
      - rtl/sync_queue.sv
      - rtl/dispatch_router.sv
      - rtl/decode_frontend.sv
      - target: test
        files:
          - verif/decode_frontend_properties.sv
          - verif/decode_frontend_tb.sv
